// ==== mipsTrace.f ====
src/mipsTracePkg.sv
src/instDec.sv
src/instClassify.sv
src/classCounter.sv
src/traceTop.sv
verification/traceTop_sva.sv
verification/traceTopTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the retire-trace monitor testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module traceTopTb \
	-f mipsTrace.f -o traceSim

output=$(./obj_dir/traceSim +verilator+error+limit+1000) || true
echo "$output"
if echo "$output" | grep -qx "Test OK"; then
	exit 0
fi
exit 1

// ==== src/classCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module classCounter (
	input logic clk,
	input logic rstN,
	input logic countEnable,
	input logic [mipsTracePkg::classWidth-1:0] countClass,
	input logic countClear,
	input logic [mipsTracePkg::classWidth-1:0] countSel,
	output logic [mipsTracePkg::countWidth-1:0] countValue
);

	logic [mipsTracePkg::countWidth-1:0] counts [mipsTracePkg::classCount];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < mipsTracePkg::classCount; i++)
				counts[i] <= '0;
		end else if (countClear) begin
			// clear beats a record on the same edge.
			for (int i = 0; i < mipsTracePkg::classCount; i++)
				counts[i] <= '0;
		end else if (countEnable) begin
			counts[countClass] <= counts[countClass] + 1'b1;
		end
	end

	assign countValue = counts[countSel];

endmodule

`default_nettype wire

// ==== src/instClassify.sv ====
`timescale 1ns/1ps
`default_nettype none

module instClassify (
	input mipsTracePkg::instrWord instr,
	output logic [mipsTracePkg::classWidth-1:0] instrClass,
	output logic [4:0] destReg
);

	logic [4:0] rd;
	logic [4:0] rt;

	assign rd = instr.rType.rd;
	assign rt = instr.iType.rt;

	always_comb begin
		instrClass = mipsTracePkg::clsNone;
		destReg = 5'd0;
		case (instr.iType.op)
			mipsTracePkg::opSpecial: begin
				case (instr.rType.funct)
					mipsTracePkg::functAdd, mipsTracePkg::functAddu, mipsTracePkg::functSub,
					mipsTracePkg::functSubu, mipsTracePkg::functSlt, mipsTracePkg::functSltu,
					mipsTracePkg::functAnd, mipsTracePkg::functOr, mipsTracePkg::functXor,
					mipsTracePkg::functNor, mipsTracePkg::functSll, mipsTracePkg::functSllv,
					mipsTracePkg::functSrl, mipsTracePkg::functSrlv, mipsTracePkg::functSra,
					mipsTracePkg::functSrav, mipsTracePkg::functMovn,
					mipsTracePkg::functMovz: begin
						instrClass = mipsTracePkg::clsAlu;
						destReg = rd;
					end
					mipsTracePkg::functMfhi, mipsTracePkg::functMflo: begin
						instrClass = mipsTracePkg::clsMulDiv;
						destReg = rd;
					end
					mipsTracePkg::functMthi, mipsTracePkg::functMtlo, mipsTracePkg::functMult,
					mipsTracePkg::functMultu, mipsTracePkg::functDiv,
					mipsTracePkg::functDivu: instrClass = mipsTracePkg::clsMulDiv;
					mipsTracePkg::functJr: instrClass = mipsTracePkg::clsJump;
					mipsTracePkg::functJalr: begin
						instrClass = mipsTracePkg::clsJump;
						destReg = rd;
					end
					mipsTracePkg::functSyscall,
					mipsTracePkg::functBreak: instrClass = mipsTracePkg::clsSystem;
					default: instrClass = mipsTracePkg::clsNone;
				endcase
			end
			mipsTracePkg::opRegimm: begin
				case (rt)
					mipsTracePkg::rtBltz, mipsTracePkg::rtBgez: instrClass = mipsTracePkg::clsBranch;
					mipsTracePkg::rtBltzal, mipsTracePkg::rtBgezal: begin
						instrClass = mipsTracePkg::clsBranch;
						destReg = 5'd31;
					end
					default: instrClass = mipsTracePkg::clsNone;
				endcase
			end
			mipsTracePkg::opBeq, mipsTracePkg::opBne, mipsTracePkg::opBlez,
			mipsTracePkg::opBgtz: instrClass = mipsTracePkg::clsBranch;
			mipsTracePkg::opAddi, mipsTracePkg::opAddiu, mipsTracePkg::opSlti,
			mipsTracePkg::opSltiu, mipsTracePkg::opAndi, mipsTracePkg::opOri,
			mipsTracePkg::opXori, mipsTracePkg::opLui: begin
				instrClass = mipsTracePkg::clsAlu;
				destReg = rt;
			end
			mipsTracePkg::opLb, mipsTracePkg::opLbu, mipsTracePkg::opLh, mipsTracePkg::opLhu,
			mipsTracePkg::opLw, mipsTracePkg::opLwl, mipsTracePkg::opLwr,
			mipsTracePkg::opLl: begin
				instrClass = mipsTracePkg::clsLoad;
				destReg = rt;
			end
			mipsTracePkg::opSb, mipsTracePkg::opSh, mipsTracePkg::opSw, mipsTracePkg::opSwl,
			mipsTracePkg::opSwr: instrClass = mipsTracePkg::clsStore;
			mipsTracePkg::opJ: instrClass = mipsTracePkg::clsJump;
			mipsTracePkg::opJal: begin
				instrClass = mipsTracePkg::clsJump;
				destReg = 5'd31;
			end
			mipsTracePkg::opCop0: begin
				if (instr.rType.rs == mipsTracePkg::rsMfc0) begin
					instrClass = mipsTracePkg::clsSystem;
					destReg = rt;
				end else if (instr.rType.rs == mipsTracePkg::rsMtc0)
					instrClass = mipsTracePkg::clsSystem;
			end
			mipsTracePkg::opSpecial2: begin
				case (instr.rType.funct)
					mipsTracePkg::functClo, mipsTracePkg::functClz: begin
						instrClass = mipsTracePkg::clsAlu;
						destReg = rd;
					end
					mipsTracePkg::functMul: begin
						instrClass = mipsTracePkg::clsMulDiv;
						destReg = rd;
					end
					mipsTracePkg::functMadd, mipsTracePkg::functMaddu, mipsTracePkg::functMsub,
					mipsTracePkg::functMsubu: instrClass = mipsTracePkg::clsMulDiv;
					default: instrClass = mipsTracePkg::clsNone;
				endcase
			end
			mipsTracePkg::opSpecial3: begin
				// EXT and INS write rt, the BSHFL group writes rd.
				if (instr.rType.funct == mipsTracePkg::functExt ||
						instr.rType.funct == mipsTracePkg::functIns) begin
					instrClass = mipsTracePkg::clsAlu;
					destReg = rt;
				end else if (instr.rType.funct == mipsTracePkg::functBshfl &&
						(instr.rType.shamt == mipsTracePkg::shamtSeb ||
						instr.rType.shamt == mipsTracePkg::shamtSeh ||
						instr.rType.shamt == mipsTracePkg::shamtWsbh)) begin
					instrClass = mipsTracePkg::clsAlu;
					destReg = rd;
				end
			end
			default: instrClass = mipsTracePkg::clsNone;
		endcase
		if (instr.raw == mipsTracePkg::instrEret) begin
			instrClass = mipsTracePkg::clsSystem;
			destReg = 5'd0;
		end
		// the zero word is a nop, not an SLL to r0.
		if (~|instr.raw) begin
			instrClass = mipsTracePkg::clsNone;
			destReg = 5'd0;
		end
	end

endmodule

`default_nettype wire

// ==== src/instDec.sv ====
`timescale 1ns/1ps
`default_nettype none

module instDec (
	input mipsTracePkg::instrWord instr,
	output logic [mipsTracePkg::mnemonicWidth-1:0] ascii
);

	always_comb begin
		ascii = "N-R";
		case (instr.iType.op)
			mipsTracePkg::opSpecial: begin
				case (instr.rType.funct)
					mipsTracePkg::functAdd: ascii = "ADD";
					mipsTracePkg::functAddu: ascii = "ADDU";
					mipsTracePkg::functSub: ascii = "SUB";
					mipsTracePkg::functSubu: ascii = "SUBU";
					mipsTracePkg::functSlt: ascii = "SLT";
					mipsTracePkg::functSltu: ascii = "SLTU";
					mipsTracePkg::functAnd: ascii = "AND";
					mipsTracePkg::functOr: ascii = "OR";
					mipsTracePkg::functXor: ascii = "XOR";
					mipsTracePkg::functNor: ascii = "NOR";
					mipsTracePkg::functSll: ascii = "SLL";
					mipsTracePkg::functSllv: ascii = "SLLV";
					mipsTracePkg::functSrl: ascii = "SRL";
					mipsTracePkg::functSrlv: ascii = "SRLV";
					mipsTracePkg::functSra: ascii = "SRA";
					mipsTracePkg::functSrav: ascii = "SRAV";
					mipsTracePkg::functMovn: ascii = "MOVN";
					mipsTracePkg::functMovz: ascii = "MOVZ";
					mipsTracePkg::functMfhi: ascii = "MFHI";
					mipsTracePkg::functMflo: ascii = "MFLO";
					mipsTracePkg::functMthi: ascii = "MTHI";
					mipsTracePkg::functMtlo: ascii = "MTLO";
					mipsTracePkg::functMult: ascii = "MULT";
					mipsTracePkg::functMultu: ascii = "MULTU";
					mipsTracePkg::functDiv: ascii = "DIV";
					mipsTracePkg::functDivu: ascii = "DIVU";
					mipsTracePkg::functJr: ascii = "JR";
					mipsTracePkg::functJalr: ascii = "JALR";
					mipsTracePkg::functSyscall: ascii = "SYSC";
					mipsTracePkg::functBreak: ascii = "BREAK";
					default: ascii = "N-R";
				endcase
			end
			mipsTracePkg::opAddi: ascii = "ADDI";
			mipsTracePkg::opAddiu: ascii = "ADDIU";
			mipsTracePkg::opSlti: ascii = "SLTI";
			mipsTracePkg::opSltiu: ascii = "SLTIU";
			mipsTracePkg::opAndi: ascii = "ANDI";
			mipsTracePkg::opOri: ascii = "ORI";
			mipsTracePkg::opXori: ascii = "XORI";
			mipsTracePkg::opLui: ascii = "LUI";
			mipsTracePkg::opBeq: ascii = "BEQ";
			mipsTracePkg::opBne: ascii = "BNE";
			mipsTracePkg::opBlez: ascii = "BLEZ";
			mipsTracePkg::opBgtz: ascii = "BGTZ";
			mipsTracePkg::opRegimm: begin
				// branch kind lives in the rt slot.
				case (instr.iType.rt)
					mipsTracePkg::rtBltz: ascii = "BLTZ";
					mipsTracePkg::rtBgez: ascii = "BGEZ";
					mipsTracePkg::rtBltzal: ascii = "BLTZAL";
					mipsTracePkg::rtBgezal: ascii = "BGEZAL";
					default: ascii = "N-R";
				endcase
			end
			mipsTracePkg::opLb: ascii = "LB";
			mipsTracePkg::opLbu: ascii = "LBU";
			mipsTracePkg::opLh: ascii = "LH";
			mipsTracePkg::opLhu: ascii = "LHU";
			mipsTracePkg::opLw: ascii = "LW";
			mipsTracePkg::opLwl: ascii = "LWL";
			mipsTracePkg::opLwr: ascii = "LWR";
			mipsTracePkg::opLl: ascii = "LL";
			mipsTracePkg::opSb: ascii = "SB";
			mipsTracePkg::opSh: ascii = "SH";
			mipsTracePkg::opSw: ascii = "SW";
			mipsTracePkg::opSwl: ascii = "SWL";
			mipsTracePkg::opSwr: ascii = "SWR";
			mipsTracePkg::opJ: ascii = "J";
			mipsTracePkg::opJal: ascii = "JAL";
			mipsTracePkg::opCop0: begin
				case (instr.rType.rs)
					mipsTracePkg::rsMfc0: ascii = "MFC0";
					mipsTracePkg::rsMtc0: ascii = "MTC0";
					default: ascii = "N-R";
				endcase
			end
			mipsTracePkg::opSpecial2: begin
				case (instr.rType.funct)
					mipsTracePkg::functClo: ascii = "CLO";
					mipsTracePkg::functClz: ascii = "CLZ";
					mipsTracePkg::functMul: ascii = "MUL";
					mipsTracePkg::functMadd: ascii = "MADD";
					mipsTracePkg::functMaddu: ascii = "MADDU";
					mipsTracePkg::functMsub: ascii = "MSUB";
					mipsTracePkg::functMsubu: ascii = "MSUBU";
					default: ascii = "N-R";
				endcase
			end
			mipsTracePkg::opSpecial3: begin
				case (instr.rType.funct)
					mipsTracePkg::functBshfl: begin
						// BSHFL picks its operation through shamt.
						case (instr.rType.shamt)
							mipsTracePkg::shamtSeb: ascii = "SEB";
							mipsTracePkg::shamtSeh: ascii = "SEH";
							mipsTracePkg::shamtWsbh: ascii = "WSBH";
							default: ascii = "N-R";
						endcase
					end
					mipsTracePkg::functExt: ascii = "EXT";
					mipsTracePkg::functIns: ascii = "INS";
					default: ascii = "N-R";
				endcase
			end
			default: ascii = "N-R";
		endcase
		// whole-word matches override the field decode.
		if (instr.raw == mipsTracePkg::instrEret)
			ascii = "ERET";
		if (~|instr.raw)
			ascii = "NOP";
	end

endmodule

`default_nettype wire

// ==== src/mipsTracePkg.sv ====
`default_nettype none

package mipsTracePkg;

	localparam int classWidth = 3;
	localparam int classCount = 8;
	localparam int countWidth = 32;
	localparam int mnemonicWidth = 48;

	// main opcode field.
	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opRegimm = 6'b000001;
	localparam logic [5:0] opJ = 6'b000010;
	localparam logic [5:0] opJal = 6'b000011;
	localparam logic [5:0] opBeq = 6'b000100;
	localparam logic [5:0] opBne = 6'b000101;
	localparam logic [5:0] opBlez = 6'b000110;
	localparam logic [5:0] opBgtz = 6'b000111;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opLui = 6'b001111;
	localparam logic [5:0] opCop0 = 6'b010000;
	localparam logic [5:0] opSpecial2 = 6'b011100;
	localparam logic [5:0] opSpecial3 = 6'b011111;
	localparam logic [5:0] opLb = 6'b100000;
	localparam logic [5:0] opLh = 6'b100001;
	localparam logic [5:0] opLwl = 6'b100010;
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opLbu = 6'b100100;
	localparam logic [5:0] opLhu = 6'b100101;
	localparam logic [5:0] opLwr = 6'b100110;
	localparam logic [5:0] opSb = 6'b101000;
	localparam logic [5:0] opSh = 6'b101001;
	localparam logic [5:0] opSwl = 6'b101010;
	localparam logic [5:0] opSw = 6'b101011;
	localparam logic [5:0] opSwr = 6'b101110;
	localparam logic [5:0] opLl = 6'b110000;

	// function field under SPECIAL.
	localparam logic [5:0] functSll = 6'b000000;
	localparam logic [5:0] functSrl = 6'b000010;
	localparam logic [5:0] functSra = 6'b000011;
	localparam logic [5:0] functSllv = 6'b000100;
	localparam logic [5:0] functSrlv = 6'b000110;
	localparam logic [5:0] functSrav = 6'b000111;
	localparam logic [5:0] functJr = 6'b001000;
	localparam logic [5:0] functJalr = 6'b001001;
	localparam logic [5:0] functMovz = 6'b001010;
	localparam logic [5:0] functMovn = 6'b001011;
	localparam logic [5:0] functSyscall = 6'b001100;
	localparam logic [5:0] functBreak = 6'b001101;
	localparam logic [5:0] functMfhi = 6'b010000;
	localparam logic [5:0] functMthi = 6'b010001;
	localparam logic [5:0] functMflo = 6'b010010;
	localparam logic [5:0] functMtlo = 6'b010011;
	localparam logic [5:0] functMult = 6'b011000;
	localparam logic [5:0] functMultu = 6'b011001;
	localparam logic [5:0] functDiv = 6'b011010;
	localparam logic [5:0] functDivu = 6'b011011;
	localparam logic [5:0] functAdd = 6'b100000;
	localparam logic [5:0] functAddu = 6'b100001;
	localparam logic [5:0] functSub = 6'b100010;
	localparam logic [5:0] functSubu = 6'b100011;
	localparam logic [5:0] functAnd = 6'b100100;
	localparam logic [5:0] functOr = 6'b100101;
	localparam logic [5:0] functXor = 6'b100110;
	localparam logic [5:0] functNor = 6'b100111;
	localparam logic [5:0] functSlt = 6'b101010;
	localparam logic [5:0] functSltu = 6'b101011;

	// SPECIAL2 and SPECIAL3 function codes.
	localparam logic [5:0] functMadd = 6'b000000;
	localparam logic [5:0] functMaddu = 6'b000001;
	localparam logic [5:0] functMul = 6'b000010;
	localparam logic [5:0] functMsub = 6'b000100;
	localparam logic [5:0] functMsubu = 6'b000101;
	localparam logic [5:0] functClz = 6'b100000;
	localparam logic [5:0] functClo = 6'b100001;
	localparam logic [5:0] functExt = 6'b000000;
	localparam logic [5:0] functIns = 6'b000100;
	localparam logic [5:0] functBshfl = 6'b100000;

	localparam logic [4:0] shamtWsbh = 5'b00010;
	localparam logic [4:0] shamtSeb = 5'b10000;
	localparam logic [4:0] shamtSeh = 5'b11000;

	localparam logic [4:0] rtBltz = 5'b00000;
	localparam logic [4:0] rtBgez = 5'b00001;
	localparam logic [4:0] rtBltzal = 5'b10000;
	localparam logic [4:0] rtBgezal = 5'b10001;

	localparam logic [4:0] rsMfc0 = 5'b00000;
	localparam logic [4:0] rsMtc0 = 5'b00100;

	localparam logic [31:0] instrEret = 32'h4200_0018;

	localparam logic [classWidth-1:0] clsNone = 3'd0;
	localparam logic [classWidth-1:0] clsAlu = 3'd1;
	localparam logic [classWidth-1:0] clsMulDiv = 3'd2;
	localparam logic [classWidth-1:0] clsBranch = 3'd3;
	localparam logic [classWidth-1:0] clsJump = 3'd4;
	localparam logic [classWidth-1:0] clsLoad = 3'd5;
	localparam logic [classWidth-1:0] clsStore = 3'd6;
	localparam logic [classWidth-1:0] clsSystem = 3'd7;

	// one instruction word seen as R-type or I-type fields.
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} iType;
	} instrWord;

endpackage

`default_nettype wire

// ==== src/traceTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module traceTop (
	input logic clk,
	input logic rstN,
	input logic retire,
	input logic [31:0] retirePc,
	input logic [31:0] retireInstr,
	input logic countClear,
	input logic [mipsTracePkg::classWidth-1:0] countSel,
	output logic traceValid,
	output logic [31:0] tracePc,
	output logic [31:0] traceInstr,
	output logic [mipsTracePkg::mnemonicWidth-1:0] traceMnemonic,
	output logic [mipsTracePkg::classWidth-1:0] traceClass,
	output logic [4:0] traceDest,
	output logic [mipsTracePkg::countWidth-1:0] countValue
);

	logic validQ;
	logic [31:0] pcQ;
	mipsTracePkg::instrWord instrQ;

	// a record leaves one clock after its retire.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
			pcQ <= '0;
			instrQ.raw <= '0;
		end else begin
			validQ <= retire;
			if (retire) begin
				pcQ <= retirePc;
				instrQ.raw <= retireInstr;
			end
		end
	end

	instDec dec0 (
		.instr(instrQ),
		.ascii(traceMnemonic)
	);

	instClassify classify0 (
		.instr(instrQ),
		.instrClass(traceClass),
		.destReg(traceDest)
	);

	classCounter counter0 (
		.clk(clk),
		.rstN(rstN),
		.countEnable(validQ),
		.countClass(traceClass),
		.countClear(countClear),
		.countSel(countSel),
		.countValue(countValue)
	);

	assign traceValid = validQ;
	assign tracePc = pcQ;
	assign traceInstr = instrQ.raw;

endmodule

`default_nettype wire

// ==== verification/traceTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module traceTopTb;

	localparam int tableSize = 19;
	localparam int resetCycles = 10;
	localparam int unknownRetires = 8;
	localparam int randomRetires = 800;
	localparam int testCycles = resetCycles + 3 * tableSize + unknownRetires + randomRetires +
		4 * mipsTracePkg::classCount + 20;
	localparam int cycleLimit = 2 * testCycles;

	// one encoding per mnemonic group and the class each one retires as.
	localparam logic [31:0] tableWord [tableSize] = '{
		32'h0022_1821, 32'h0085_0018, 32'h0000_3810, 32'h03e0_0008, 32'h0000_000c,
		32'h2509_0005, 32'h3c0a_1234, 32'h8fab_0008, 32'hafac_0004, 32'h1022_0004,
		32'h0491_0008, 32'h0800_0100, 32'h0c00_0200, 32'h400d_6000, 32'h7022_7802,
		32'h7030_8020, 32'h7c02_8c20, 32'h4200_0018, 32'h0000_0000
	};
	localparam logic [2:0] tableClass [tableSize] = '{
		mipsTracePkg::clsAlu, mipsTracePkg::clsMulDiv, mipsTracePkg::clsMulDiv,
		mipsTracePkg::clsJump, mipsTracePkg::clsSystem, mipsTracePkg::clsAlu,
		mipsTracePkg::clsAlu, mipsTracePkg::clsLoad, mipsTracePkg::clsStore,
		mipsTracePkg::clsBranch, mipsTracePkg::clsBranch, mipsTracePkg::clsJump,
		mipsTracePkg::clsJump, mipsTracePkg::clsSystem, mipsTracePkg::clsMulDiv,
		mipsTracePkg::clsAlu, mipsTracePkg::clsAlu, mipsTracePkg::clsSystem,
		mipsTracePkg::clsNone
	};

	logic clk;
	logic rstN;
	logic retire;
	logic [31:0] retirePc;
	logic [31:0] retireInstr;
	logic countClear;
	logic [mipsTracePkg::classWidth-1:0] countSel;
	logic traceValid;
	logic [31:0] tracePc;
	logic [31:0] traceInstr;
	logic [mipsTracePkg::mnemonicWidth-1:0] traceMnemonic;
	logic [mipsTracePkg::classWidth-1:0] traceClass;
	logic [4:0] traceDest;
	logic [mipsTracePkg::countWidth-1:0] countValue;

	logic [31:0] seed;
	logic [31:0] tally [mipsTracePkg::classCount];
	int errors;
	int passCount;
	int failCount;
	int cycles = 0;

	traceTop dut0 (
		.clk(clk),
		.rstN(rstN),
		.retire(retire),
		.retirePc(retirePc),
		.retireInstr(retireInstr),
		.countClear(countClear),
		.countSel(countSel),
		.traceValid(traceValid),
		.tracePc(tracePc),
		.traceInstr(traceInstr),
		.traceMnemonic(traceMnemonic),
		.traceClass(traceClass),
		.traceDest(traceDest),
		.countValue(countValue)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int failuresSoFar();
		return errors + dut0.sva0.failures;
	endfunction

	task automatic clearTally();
		for (int c = 0; c < mipsTracePkg::classCount; c++)
			tally[c] = '0;
	endtask

	task automatic issue(input logic [31:0] pc, input logic [31:0] word, input logic [2:0] cls);
		retire <= 1'b1;
		retirePc <= pc;
		retireInstr <= word;
		tally[cls] = tally[cls] + 32'd1;
		@(posedge clk);
	endtask

	task automatic idle();
		retire <= 1'b0;
		@(posedge clk);
	endtask

	// countValue is combinational from countSel, so it is read half a clock later.
	task automatic checkCounts();
		logic [31:0] got;
		for (int c = 0; c < mipsTracePkg::classCount; c++) begin
			countSel <= c[2:0];
			@(negedge clk);
			got = countValue;
			if (got !== tally[c]) begin
				$display("ERR %0t countValue[%0d] expected %0d got %0d", $time, c, tally[c], got);
				errors++;
			end
			@(posedge clk);
		end
	endtask

	task automatic report(input string name, input int mark);
		int now;
		now = failuresSoFar();
		if (now == mark) begin
			passCount++;
			$display("test %s passed", name);
		end else begin
			failCount++;
			$display("test %s failed with %0d errors", name, now - mark);
		end
	endtask

	initial begin
		int mark;
		int pick;
		logic [31:0] pc;
		clk = 1'b0;
		rstN = 1'b0;
		retire = 1'b0;
		retirePc = '0;
		retireInstr = '0;
		countClear = 1'b0;
		countSel = '0;
		seed = 32'hd69b_5dcc;
		errors = 0;
		passCount = 0;
		failCount = 0;
		clearTally();

		mark = 0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);
		checkCounts();
		report("reset", mark);

		// back to back first, then with a gap after every record.
		mark = failuresSoFar();
		for (int i = 0; i < tableSize; i++)
			issue(32'h0040_0000 + 32'(i * 4), tableWord[i], tableClass[i]);
		for (int i = 0; i < tableSize; i++) begin
			issue(32'h0040_1000 + 32'(i * 4), tableWord[i], tableClass[i]);
			idle();
		end
		idle();
		report("decode table", mark);

		// the last record is checked one clock after it leaves.
		mark = failuresSoFar();
		repeat (unknownRetires) begin
			seed = xorshift(seed);
			pc = seed;
			seed = xorshift(seed);
			issue(pc, {6'h3f, seed[25:0]}, mipsTracePkg::clsNone);
		end
		idle();
		idle();
		report("unknown opcode", mark);

		mark = failuresSoFar();
		repeat (randomRetires) begin
			seed = xorshift(seed);
			pc = {seed[31:2], 2'b00};
			seed = xorshift(seed);
			pick = int'(seed[15:8]) % (tableSize + 1);
			if (seed[1:0] == 2'b00)
				idle();
			else if (pick == tableSize)
				issue(pc, {6'h3f, seed[25:0]}, mipsTracePkg::clsNone);
			else
				issue(pc, tableWord[pick], tableClass[pick]);
		end
		idle();
		idle();
		checkCounts();
		report("random counts", mark);

		// the clear lands on the same edge that would count this load.
		mark = failuresSoFar();
		issue(32'h0040_2000, tableWord[7], tableClass[7]);
		retire <= 1'b0;
		countClear <= 1'b1;
		@(posedge clk);
		countClear <= 1'b0;
		clearTally();
		idle();
		checkCounts();
		report("clear", mark);

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0 && failuresSoFar() == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/traceTop_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module traceTopSva (
	input logic clk,
	input logic rstN,
	input logic retire,
	input logic [31:0] retirePc,
	input logic [31:0] retireInstr,
	input logic traceValid,
	input logic [31:0] tracePc,
	input logic [31:0] traceInstr,
	input logic [mipsTracePkg::mnemonicWidth-1:0] traceMnemonic,
	input logic [mipsTracePkg::classWidth-1:0] traceClass,
	input logic [4:0] traceDest
);

	int failures = 0;
	logic known;
	logic [mipsTracePkg::mnemonicWidth+7:0] expected;

	// expected mnemonic, class and destination of each encoding the testbench retires.
	always_comb begin
		known = 1'b1;
		case (traceInstr)
			32'h0022_1821: expected = {48'("ADDU"), mipsTracePkg::clsAlu, 5'd3};
			32'h0085_0018: expected = {48'("MULT"), mipsTracePkg::clsMulDiv, 5'd0};
			32'h0000_3810: expected = {48'("MFHI"), mipsTracePkg::clsMulDiv, 5'd7};
			32'h03e0_0008: expected = {48'("JR"), mipsTracePkg::clsJump, 5'd0};
			32'h0000_000c: expected = {48'("SYSC"), mipsTracePkg::clsSystem, 5'd0};
			32'h2509_0005: expected = {48'("ADDIU"), mipsTracePkg::clsAlu, 5'd9};
			32'h3c0a_1234: expected = {48'("LUI"), mipsTracePkg::clsAlu, 5'd10};
			32'h8fab_0008: expected = {48'("LW"), mipsTracePkg::clsLoad, 5'd11};
			32'hafac_0004: expected = {48'("SW"), mipsTracePkg::clsStore, 5'd0};
			32'h1022_0004: expected = {48'("BEQ"), mipsTracePkg::clsBranch, 5'd0};
			32'h0491_0008: expected = {48'("BGEZAL"), mipsTracePkg::clsBranch, 5'd31};
			32'h0800_0100: expected = {48'("J"), mipsTracePkg::clsJump, 5'd0};
			32'h0c00_0200: expected = {48'("JAL"), mipsTracePkg::clsJump, 5'd31};
			32'h400d_6000: expected = {48'("MFC0"), mipsTracePkg::clsSystem, 5'd13};
			32'h7022_7802: expected = {48'("MUL"), mipsTracePkg::clsMulDiv, 5'd15};
			32'h7030_8020: expected = {48'("CLZ"), mipsTracePkg::clsAlu, 5'd16};
			32'h7c02_8c20: expected = {48'("SEB"), mipsTracePkg::clsAlu, 5'd17};
			mipsTracePkg::instrEret: expected = {48'("ERET"), mipsTracePkg::clsSystem, 5'd0};
			32'h0000_0000: expected = {48'("NOP"), mipsTracePkg::clsNone, 5'd0};
			default: begin
				// opcode 6'h3f is unused, anything else is not checked here.
				known = traceInstr[31:26] == 6'h3f;
				expected = {48'("N-R"), mipsTracePkg::clsNone, 5'd0};
			end
		endcase
	end

	recordAfterRetire: assert property (@(posedge clk) disable iff (!rstN)
		retire |=> traceValid && tracePc == $past(retirePc) && traceInstr == $past(retireInstr))
		else begin
			failures++;
			$error("no record, or a wrong pc or word, one clock after a retire");
		end

	noRecordWithoutRetire: assert property (@(posedge clk) disable iff (!rstN)
		!retire |=> !traceValid)
		else begin
			failures++;
			$error("record appeared without a retire");
		end

	quietInReset: assert property (@(posedge clk) !rstN |-> !traceValid)
		else begin
			failures++;
			$error("record valid during reset");
		end

	mnemonicMatches: assert property (@(posedge clk) disable iff (!rstN)
		traceValid && known |-> traceMnemonic == expected[mipsTracePkg::mnemonicWidth+7:8])
		else begin
			failures++;
			$error("wrong mnemonic for word %h", traceInstr);
		end

	classAndDestMatch: assert property (@(posedge clk) disable iff (!rstN)
		traceValid && known |-> {traceClass, traceDest} == expected[7:0])
		else begin
			failures++;
			$error("wrong class or destination for word %h", traceInstr);
		end

endmodule

bind traceTop traceTopSva sva0 (
	.clk(clk),
	.rstN(rstN),
	.retire(retire),
	.retirePc(retirePc),
	.retireInstr(retireInstr),
	.traceValid(traceValid),
	.tracePc(tracePc),
	.traceInstr(traceInstr),
	.traceMnemonic(traceMnemonic),
	.traceClass(traceClass),
	.traceDest(traceDest)
);

`default_nettype wire
